// ==== compile.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/control_unit.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/decode_stage.sv
testbench/decode_stage_tb.sv

// ==== logic/control_unit.sv ====
// ====================
// Control unit, opcode/funct3 decode to control bundle
// ====================
`default_nettype none

module control_unit (
    input  logic [4:0]           opcode,
    input  logic [2:0]           funct3,
    output core_ctrl_pkg::ctrl_t ctrl
);

    typedef core_ctrl_pkg::ctrl_t ctrl_t;

    // Row = {brk, sys} + ALU class + {exec_a, exec_b, mem_w, reg_w, mem2reg, bra, jmp}
    function automatic ctrl_t mk(input logic [1:0] flags, input core_ctrl_pkg::alu_op_e op,
                                 input logic [6:0] fmt);
        mk = {flags, op, fmt};
    endfunction

    // exec_a 1 = pc, exec_b 1 = imm
    localparam ctrl_t lui_row     = mk(2'b00, core_ctrl_pkg::alu_lui,     7'b0101000);
    localparam ctrl_t auipc_row   = mk(2'b00, core_ctrl_pkg::alu_auipc,   7'b1101000);
    localparam ctrl_t jal_row     = mk(2'b00, core_ctrl_pkg::alu_j,       7'b1001001);
    localparam ctrl_t jalr_row    = mk(2'b00, core_ctrl_pkg::alu_i_jump,  7'b1001001);
    localparam ctrl_t branch_row  = mk(2'b00, core_ctrl_pkg::alu_b,       7'b0000010);
    localparam ctrl_t load_row    = mk(2'b00, core_ctrl_pkg::alu_i_load,  7'b0101100);
    localparam ctrl_t store_row   = mk(2'b00, core_ctrl_pkg::alu_s,       7'b0110000);
    localparam ctrl_t arith_row   = mk(2'b00, core_ctrl_pkg::alu_i_arith, 7'b0101000);
    localparam ctrl_t r_row       = mk(2'b00, core_ctrl_pkg::alu_r,       7'b0001000);
    localparam ctrl_t fence_row   = mk(2'b00, core_ctrl_pkg::alu_fence,   7'b0100000);
    localparam ctrl_t ecall_row   = mk(2'b01, core_ctrl_pkg::alu_sys,     7'b0100000);
    localparam ctrl_t invalid_row = mk(2'b10, core_ctrl_pkg::alu_r,       7'b0000000);

    ctrl_t cm_row;
    ctrl_t funct_row;
    logic  funct_sel;

    always_comb begin
        casez ({funct3, opcode})
            {3'b???, rv_isa_pkg::op_lui}                     : cm_row = lui_row;
            {3'b???, rv_isa_pkg::op_auipc}                   : cm_row = auipc_row;
            {3'b???, rv_isa_pkg::op_jal}                     : cm_row = jal_row;
            {3'b???, rv_isa_pkg::op_jalr}                    : cm_row = jalr_row;
            {rv_isa_pkg::f3_byte,   rv_isa_pkg::op_load},
            {rv_isa_pkg::f3_half,   rv_isa_pkg::op_load},
            {rv_isa_pkg::f3_word,   rv_isa_pkg::op_load},
            {rv_isa_pkg::f3_byte_u, rv_isa_pkg::op_load},
            {rv_isa_pkg::f3_half_u, rv_isa_pkg::op_load}     : cm_row = load_row;
            {rv_isa_pkg::f3_byte,   rv_isa_pkg::op_store},
            {rv_isa_pkg::f3_half,   rv_isa_pkg::op_store},
            {rv_isa_pkg::f3_word,   rv_isa_pkg::op_store}    : cm_row = store_row;
            {rv_isa_pkg::f3_beq,    rv_isa_pkg::op_branch},
            {rv_isa_pkg::f3_bne,    rv_isa_pkg::op_branch},
            {rv_isa_pkg::f3_blt,    rv_isa_pkg::op_branch},
            {rv_isa_pkg::f3_bge,    rv_isa_pkg::op_branch},
            {rv_isa_pkg::f3_bltu,   rv_isa_pkg::op_branch},
            {rv_isa_pkg::f3_bgeu,   rv_isa_pkg::op_branch}   : cm_row = branch_row;
            {3'b???, rv_isa_pkg::op_op_imm}                  : cm_row = arith_row; // All 8 legal
            {rv_isa_pkg::f3_priv,   rv_isa_pkg::op_system}   : cm_row = ecall_row;
            {rv_isa_pkg::f3_fence,  rv_isa_pkg::op_misc_mem} : cm_row = fence_row;
            default                                          : cm_row = invalid_row;
        endcase

        // R-type row from funct3 alone
        case (funct3)
            rv_isa_pkg::f3_add, rv_isa_pkg::f3_sll, rv_isa_pkg::f3_slt, rv_isa_pkg::f3_sltu,
            rv_isa_pkg::f3_xor, rv_isa_pkg::f3_sr,  rv_isa_pkg::f3_or,  rv_isa_pkg::f3_and:
                funct_row = r_row;
            default:
                funct_row = invalid_row;
        endcase
    end

    assign funct_sel = (opcode == rv_isa_pkg::op_op);
    assign ctrl      = funct_sel ? funct_row : cm_row;

    always_comb begin
        if (!$isunknown({funct3, opcode})) begin
            a_no_dual_write: assert final (!(ctrl.mem_write && ctrl.reg_write));
            a_brk_no_write: assert final (!ctrl.brk || !(ctrl.mem_write || ctrl.reg_write));
        end
    end

endmodule

`default_nettype wire

// ==== logic/core_cfg.svh ====
// ====================
// Core configuration, widths and register file size
// ====================
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// RV32I only
`define CORE_XLEN      32
`define CORE_REG_COUNT 32
`define CORE_REG_AW    5

`endif

// ==== logic/core_ctrl_pkg.sv ====
// ====================
// Decode control bundle and ID/EX pipeline types
// ====================
`default_nettype none

`include "core_cfg.svh"

package core_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_lui,
        alu_auipc,
        alu_j,
        alu_i_jump,
        alu_b,
        alu_i_load,
        alu_s,
        alu_i_arith,
        alu_r,
        alu_fence,
        alu_sys
    } alu_op_e;

    typedef enum logic {
        opa_reg = 1'b0,
        opa_pc  = 1'b1
    } opa_sel_e;

    typedef enum logic {
        opb_reg = 1'b0,
        opb_imm = 1'b1
    } opb_sel_e;

    typedef struct packed {
        logic     brk;        // Illegal instruction
        logic     sys;
        alu_op_e  alu_op;
        opa_sel_e exec_a;
        opb_sel_e exec_b;
        logic     mem_write;
        logic     reg_write;
        logic     mem_to_reg;
        logic     branch;
        logic     jump;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`CORE_XLEN-1:0]   imm;
        logic [`CORE_XLEN-1:0]   rs1_data;
        logic [`CORE_XLEN-1:0]   rs2_data;
        logic [`CORE_REG_AW-1:0] rd;
        logic [2:0]              funct3;
        logic                    alt;       // Instr bit 30, SUB/SRA
    } id_ex_t;

endpackage

`default_nettype wire

// ==== logic/decode_stage.sv ====
// ====================
// RV32I decode stage with ID/EX register
// ====================
`default_nettype none

`include "core_cfg.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  logic [`CORE_XLEN-1:0]   instr,
    input  logic                    wb_en,
    input  logic [`CORE_REG_AW-1:0] wb_addr,
    input  logic [`CORE_XLEN-1:0]   wb_data,
    output logic                    out_valid,
    output core_ctrl_pkg::id_ex_t   id_ex
);

    rv_isa_pkg::instr_u    instr_v;
    core_ctrl_pkg::ctrl_t  ctrl;
    logic [`CORE_XLEN-1:0] imm;
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;
    core_ctrl_pkg::id_ex_t id_ex_d;

    assign instr_v = instr;

    control_unit u_control_unit (
        .opcode (instr_v.r.opcode),
        .funct3 (instr_v.r.funct3),
        .ctrl   (ctrl)
    );

    imm_gen u_imm_gen (
        .instr (instr_v),
        .imm   (imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (instr_v.r.rs1),
        .rs2      (instr_v.r.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    always_comb begin
        id_ex_d.ctrl     = ctrl;
        id_ex_d.imm      = imm;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.rd       = instr_v.r.rd;
        id_ex_d.funct3   = instr_v.r.funct3;
        id_ex_d.alt      = instr_v.r.funct7[5]; // Bit 30
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            id_ex     <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                id_ex <= id_ex_d;   // Bubbles keep the last bundle
            end
        end
    end

    // Accepted words must be fully defined
    a_instr_known: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> !$isunknown(instr));

endmodule

`default_nettype wire

// ==== logic/imm_gen.sv ====
// ====================
// Immediate generator for I, S, B, U and J formats
// ====================
`default_nettype none

`include "core_cfg.svh"

module imm_gen (
    input  rv_isa_pkg::instr_u    instr,
    output logic [`CORE_XLEN-1:0] imm
);

    always_comb begin
        case (instr.i.opcode)
            rv_isa_pkg::op_store: begin
                imm = {{(`CORE_XLEN-12){instr.s.imm_11_5[6]}},
                       instr.s.imm_11_5,
                       instr.s.imm_4_0};
            end
            rv_isa_pkg::op_branch: begin
                imm = {{(`CORE_XLEN-12){instr.b.imm_12}},
                       instr.b.imm_11,
                       instr.b.imm_10_5,
                       instr.b.imm_4_1,
                       1'b0};                                  // Halfword aligned
            end
            rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc: begin
                imm = {instr.u.imm_31_12, 12'b0};
            end
            rv_isa_pkg::op_jal: begin
                imm = {{(`CORE_XLEN-20){instr.j.imm_20}},
                       instr.j.imm_19_12,
                       instr.j.imm_11,
                       instr.j.imm_10_1,
                       1'b0};
            end
            default: begin
                // I format, also covers jalr, loads, op-imm and system
                imm = {{(`CORE_XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
// ====================
// Register file, 2 read / 1 write, x0 hardwired
// ====================
`default_nettype none

`include "core_cfg.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`CORE_REG_AW-1:0] rs1,
    input  logic [`CORE_REG_AW-1:0] rs2,
    output logic [`CORE_XLEN-1:0]   rs1_data,
    output logic [`CORE_XLEN-1:0]   rs2_data,
    input  logic                    wb_en,
    input  logic [`CORE_REG_AW-1:0] wb_addr,
    input  logic [`CORE_XLEN-1:0]   wb_data
);

    logic [`CORE_XLEN-1:0] regs [1:`CORE_REG_COUNT-1]; // No storage for x0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Same-cycle writeback bypasses the array
    function automatic logic [`CORE_XLEN-1:0] read_port(input logic [`CORE_REG_AW-1:0] addr);
        if (addr == '0) begin
            read_port = '0;
        end else if (wb_en && (wb_addr == addr)) begin
            read_port = wb_data;
        end else begin
            read_port = regs[addr];
        end
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    a_wb_data_known: assert property (@(posedge clk) disable iff (!arst_n)
        wb_en |-> !$isunknown(wb_data));

endmodule

`default_nettype wire

// ==== logic/rv_isa_pkg.sv ====
// ====================
// RV32I base encodings and instruction format views
// ====================
`default_nettype none

`include "core_cfg.svh"

package rv_isa_pkg;

    // Opcodes without the low 2'b11
    localparam logic [4:0] op_lui      = 5'b01101;
    localparam logic [4:0] op_auipc    = 5'b00101;
    localparam logic [4:0] op_jal      = 5'b11011;
    localparam logic [4:0] op_jalr     = 5'b11001;
    localparam logic [4:0] op_branch   = 5'b11000;
    localparam logic [4:0] op_load     = 5'b00000;
    localparam logic [4:0] op_store    = 5'b01000;
    localparam logic [4:0] op_op_imm   = 5'b00100;
    localparam logic [4:0] op_op       = 5'b01100;
    localparam logic [4:0] op_misc_mem = 5'b00011;
    localparam logic [4:0] op_system   = 5'b11100;

    localparam logic [2:0] f3_beq    = 3'b000;
    localparam logic [2:0] f3_bne    = 3'b001;
    localparam logic [2:0] f3_blt    = 3'b100;
    localparam logic [2:0] f3_bge    = 3'b101;
    localparam logic [2:0] f3_bltu   = 3'b110;
    localparam logic [2:0] f3_bgeu   = 3'b111;
    localparam logic [2:0] f3_byte   = 3'b000; // Loads and stores
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;
    localparam logic [2:0] f3_add    = 3'b000; // OP and OP-IMM
    localparam logic [2:0] f3_sll    = 3'b001;
    localparam logic [2:0] f3_slt    = 3'b010;
    localparam logic [2:0] f3_sltu   = 3'b011;
    localparam logic [2:0] f3_xor    = 3'b100;
    localparam logic [2:0] f3_sr     = 3'b101; // SRL/SRA, bit 30 picks
    localparam logic [2:0] f3_or     = 3'b110;
    localparam logic [2:0] f3_and    = 3'b111;
    localparam logic [2:0] f3_fence  = 3'b000;
    localparam logic [2:0] f3_priv   = 3'b000; // ECALL/EBREAK

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [4:0] opcode;
        logic [1:0] quad;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  quad;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [4:0] opcode;
        logic [1:0] quad;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [4:0] opcode;
        logic [1:0] quad;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  quad;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [4:0] opcode;
        logic [1:0] quad;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t                r;
        i_fmt_t                i;
        s_fmt_t                s;
        b_fmt_t                b;
        u_fmt_t                u;
        j_fmt_t                j;
        logic [`CORE_XLEN-1:0] raw;
    } instr_u;

endpackage

`default_nettype wire

// ==== testbench/decode_stage_tb.sv ====
// ====================
// Decode stage testbench with reference model and checker
// ====================
`default_nettype none

`include "core_cfg.svh"

module decode_stage_tb;

    localparam int num_reads   = 32;
    localparam int num_passes  = 2;
    localparam int num_illegal = 40;
    localparam int num_tests   = num_reads + num_passes * 64 + num_illegal;
    localparam int timeout     = (num_tests + 50) * 20 * 2;

    logic                    clk;
    logic                    arst_n;
    logic                    in_valid;
    logic [`CORE_XLEN-1:0]   instr;
    logic                    wb_en;
    logic [`CORE_REG_AW-1:0] wb_addr;
    logic [`CORE_XLEN-1:0]   wb_data;
    logic                    out_valid;
    core_ctrl_pkg::id_ex_t   id_ex;

    logic [`CORE_XLEN-1:0] model_regs [`CORE_REG_COUNT];
    core_ctrl_pkg::id_ex_t exp_q [$];
    core_ctrl_pkg::id_ex_t exp;
    logic [7:0]            legal_pairs [$];   // {opcode, funct3}
    logic                  last_in_valid;
    integer                seed;

    decode_stage dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .out_valid (out_valid),
        .id_ex     (id_ex)
    );

    always #10 clk = ~clk;

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] want);
        if (got !== want) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, want);
            $display("Finished with errors");
            $fatal(1, "decode stage mismatch");
        end
    endtask

    function automatic logic is_legal(input logic [4:0] op, input logic [2:0] f3);
        case (op)
            rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc, rv_isa_pkg::op_jal,
            rv_isa_pkg::op_jalr, rv_isa_pkg::op_op_imm, rv_isa_pkg::op_op:
                is_legal = 1'b1;              // funct3 not restricted
            rv_isa_pkg::op_load:     is_legal = (f3 != 3'b011) && (f3 < 3'b110);
            rv_isa_pkg::op_store:    is_legal = (f3 <= 3'b010);
            rv_isa_pkg::op_branch:   is_legal = (f3 != 3'b010) && (f3 != 3'b011);
            rv_isa_pkg::op_misc_mem: is_legal = (f3 == 3'b000);
            rv_isa_pkg::op_system:   is_legal = (f3 == 3'b000);
            default:                 is_legal = 1'b0;
        endcase
    endfunction

    function automatic core_ctrl_pkg::ctrl_t row(input core_ctrl_pkg::alu_op_e op,
                                                 input logic a, input logic b,
                                                 input logic mw, input logic rw,
                                                 input logic m2r, input logic br,
                                                 input logic j);
        row            = '0;
        row.alu_op     = op;
        row.exec_a     = core_ctrl_pkg::opa_sel_e'(a);
        row.exec_b     = core_ctrl_pkg::opb_sel_e'(b);
        row.mem_write  = mw;
        row.reg_write  = rw;
        row.mem_to_reg = m2r;
        row.branch     = br;
        row.jump       = j;
    endfunction

    function automatic core_ctrl_pkg::ctrl_t expected_ctrl(input logic [4:0] op,
                                                           input logic [2:0] f3);
        expected_ctrl = row(core_ctrl_pkg::alu_r, 0, 0, 0, 0, 0, 0, 0);
        if (!is_legal(op, f3)) begin
            expected_ctrl.brk = 1'b1;
        end else begin
            case (op)
            rv_isa_pkg::op_lui:      expected_ctrl = row(core_ctrl_pkg::alu_lui, 0, 1, 0, 1, 0, 0, 0);
            rv_isa_pkg::op_auipc:    expected_ctrl = row(core_ctrl_pkg::alu_auipc, 1, 1, 0, 1, 0, 0, 0);
            rv_isa_pkg::op_jal:      expected_ctrl = row(core_ctrl_pkg::alu_j, 1, 0, 0, 1, 0, 0, 1);
            rv_isa_pkg::op_jalr:     expected_ctrl = row(core_ctrl_pkg::alu_i_jump, 1, 0, 0, 1, 0, 0, 1);
            rv_isa_pkg::op_branch:   expected_ctrl = row(core_ctrl_pkg::alu_b, 0, 0, 0, 0, 0, 1, 0);
            rv_isa_pkg::op_load:     expected_ctrl = row(core_ctrl_pkg::alu_i_load, 0, 1, 0, 1, 1, 0, 0);
            rv_isa_pkg::op_store:    expected_ctrl = row(core_ctrl_pkg::alu_s, 0, 1, 1, 0, 0, 0, 0);
            rv_isa_pkg::op_op_imm:   expected_ctrl = row(core_ctrl_pkg::alu_i_arith, 0, 1, 0, 1, 0, 0, 0);
            rv_isa_pkg::op_op:       expected_ctrl = row(core_ctrl_pkg::alu_r, 0, 0, 0, 1, 0, 0, 0);
            rv_isa_pkg::op_misc_mem: expected_ctrl = row(core_ctrl_pkg::alu_fence, 0, 1, 0, 0, 0, 0, 0);
            default:                 expected_ctrl = row(core_ctrl_pkg::alu_sys, 0, 1, 0, 0, 0, 0, 0);
            endcase
            expected_ctrl.sys = (op == rv_isa_pkg::op_system);
        end
    endfunction

    function automatic logic [`CORE_XLEN-1:0] expected_imm(input logic [`CORE_XLEN-1:0] w);
        case (w[6:2])
            rv_isa_pkg::op_store:  expected_imm = {{20{w[31]}}, w[31:25], w[11:7]};
            rv_isa_pkg::op_branch: expected_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            rv_isa_pkg::op_lui,
            rv_isa_pkg::op_auipc:  expected_imm = {w[31:12], 12'b0};
            rv_isa_pkg::op_jal:    expected_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:               expected_imm = {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    // Model read with same-cycle writeback bypass
    function automatic logic [`CORE_XLEN-1:0] read_model(input logic [4:0] addr,
                                                        input logic wen, input logic [4:0] waddr,
                                                        input logic [`CORE_XLEN-1:0] wdata);
        if (addr == '0) begin
            read_model = '0;
        end else if (wen && (waddr == addr)) begin
            read_model = wdata;
        end else begin
            read_model = model_regs[addr];
        end
    endfunction

    function automatic core_ctrl_pkg::id_ex_t ref_decode(input logic [`CORE_XLEN-1:0] w,
                                                         input logic wen, input logic [4:0] waddr,
                                                         input logic [`CORE_XLEN-1:0] wdata);
        ref_decode.ctrl     = expected_ctrl(w[6:2], w[14:12]);
        ref_decode.imm      = expected_imm(w);
        ref_decode.rs1_data = read_model(w[19:15], wen, waddr, wdata);
        ref_decode.rs2_data = read_model(w[24:20], wen, waddr, wdata);
        ref_decode.rd       = w[11:7];
        ref_decode.funct3   = w[14:12];
        ref_decode.alt      = w[30];
    endfunction

    task automatic drive_cycle(input logic valid, input logic [`CORE_XLEN-1:0] w,
                               input logic wen, input logic [4:0] waddr,
                               input logic [`CORE_XLEN-1:0] wdata);
        @(negedge clk);
        in_valid = valid;
        instr    = w;
        wb_en    = wen;
        wb_addr  = waddr;
        wb_data  = wdata;
        if (valid) begin
            exp_q.push_back(ref_decode(w, wen, waddr, wdata));
        end
        if (wen && (waddr != '0)) begin
            model_regs[waddr] = wdata;
        end
    endtask

    // Random writeback, aimed at rs1 or rs2 half the time
    task automatic apply_instr(input logic [`CORE_XLEN-1:0] w);
        logic                  wen;
        logic [4:0]            waddr;
        logic [`CORE_XLEN-1:0] wdata;
        if (($random(seed) & 3) == 0) begin
            drive_cycle(1'b0, $random(seed), 1'b0, '0, '0);   // Bubble
        end
        wen   = $random(seed);
        waddr = $random(seed);
        wdata = $random(seed);
        case ($random(seed) & 3)
            0:       waddr = w[19:15];
            1:       waddr = w[24:20];
            default: ;
        endcase
        drive_cycle(1'b1, w, wen, waddr, wdata);
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            last_in_valid = 1'b0;
        end else begin
            check_val("out_valid", out_valid, last_in_valid);
            if (out_valid) begin
                exp = exp_q.pop_front();
                check_val("id_ex.ctrl", id_ex.ctrl, exp.ctrl);
                check_val("id_ex.imm", id_ex.imm, exp.imm);
                check_val("id_ex.rs1_data", id_ex.rs1_data, exp.rs1_data);
                check_val("id_ex.rs2_data", id_ex.rs2_data, exp.rs2_data);
                check_val("id_ex.rd", id_ex.rd, exp.rd);
                check_val("id_ex.funct3", id_ex.funct3, exp.funct3);
                check_val("id_ex.alt", id_ex.alt, exp.alt);
            end
            last_in_valid = in_valid;
        end
    end

    initial begin
        #(timeout);
        $display("Run timed out after %0d time units", timeout);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [`CORE_XLEN-1:0] w;
        seed     = 59;
        clk      = 1'b0;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        wb_en    = 1'b0;
        wb_addr  = '0;
        wb_data  = '0;
        for (int r = 0; r < `CORE_REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        for (int p = 0; p < 256; p++) begin
            if (is_legal(p[7:3], p[2:0])) begin
                legal_pairs.push_back(p[7:0]);
            end
        end
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        check_val("id_ex", id_ex, '0);
        repeat (5) drive_cycle(1'b0, $random(seed), 1'b0, '0, '0);

        // ADD reads every register, x0 written on the first one
        for (int i = 0; i < num_reads; i++) begin
            w = {7'b0, 5'(31 - i), 5'(i), 3'b000, 5'(i), rv_isa_pkg::op_op, 2'b11};
            drive_cycle(1'b1, w, i == 0, '0, 32'hdead_beef);
        end

        for (int p = 0; p < num_passes; p++) begin
            foreach (legal_pairs[k]) begin
                w        = $random(seed);
                w[6:0]   = {legal_pairs[k][7:3], 2'b11};
                w[14:12] = legal_pairs[k][2:0];
                apply_instr(w);
            end
        end

        repeat (num_illegal) begin
            w = $random(seed);
            while (is_legal(w[6:2], w[14:12])) begin
                w = $random(seed);
            end
            apply_instr(w);
        end

        while (exp_q.size() != 0) begin
            drive_cycle(1'b0, '0, 1'b0, '0, '0);
        end
        repeat (2) drive_cycle(1'b0, '0, 1'b0, '0, '0);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
